//--- sram_dma_cfg.svh
// sram block mover configuration
// widths of the SRAM and endpoint buffer ports, block geometry
`ifndef SRAM_DMA_CFG_SVH
`define SRAM_DMA_CFG_SVH

// SRAM word address and data
`define SRAM_ADDR_W 20
`define SRAM_DATA_W 16

// endpoint buffer byte address
`define BUF_ADDR_W 9

// one block is 256 words, 512 bytes
`define BLOCK_WORDS 256
`define BLOCK_SHIFT 8

`endif

//--- sram_dma_pkg.sv
// sram block mover shared types
// vendor request codes and SRAM bus owner select
package sram_dma_pkg;

`include "sram_dma_cfg.svh"

	// vendor request codes
	typedef enum logic [7:0] {
		REQ_READ  = 8'h01,
		REQ_WRITE = 8'h02
	} dma_req_e;

	// owner of the shared SRAM pins
	typedef enum logic [1:0] {
		SEL_NONE  = 2'd0,
		SEL_READ  = 2'd1,
		SEL_WRITE = 2'd2
	} eng_sel_e;

endpackage

//--- sram_port_if.sv
// one engine's drive onto the SRAM pins
// the engine side drives address, data and strobes, the bus side returns the pin data
`include "sram_dma_cfg.svh"

interface sram_port_if;

	logic [`SRAM_ADDR_W-1:0] addr;
	logic [`SRAM_DATA_W-1:0] dq_out;
	logic                    dq_oe;
	logic                    oe_n;
	logic                    we_n;
	logic [`SRAM_DATA_W-1:0] dq_in;

	modport engine (output addr, dq_out, dq_oe, oe_n, we_n, input dq_in);

	modport bus (input addr, dq_out, dq_oe, oe_n, we_n, output dq_in);

endinterface

//--- sram_bus_ctrl.sv
// SRAM bus controller
// decodes vendor requests, starts one engine, and routes the owning
// engine onto the shared SRAM pins
`include "sram_dma_cfg.svh"

module sram_bus_ctrl (
	input  logic                    clk,
	input  logic                    reset_2,
	input  logic                    vend_req_act,
	input  logic [7:0]              vend_req_request,
	input  logic [15:0]             vend_req_val,
	input  logic                    rd_done,
	input  logic                    wr_done,
	output logic                    rd_start,
	output logic                    wr_start,
	output logic [`SRAM_ADDR_W-1:0] base_addr,
	sram_port_if.bus                rd_bus,
	sram_port_if.bus                wr_bus,
	output logic [`SRAM_ADDR_W-1:0] sram_addr,
	inout  wire  [`SRAM_DATA_W-1:0] sram_dq,
	output logic                    sram_ce_n,
	output logic                    sram_oe_n,
	output logic                    sram_we_n,
	output logic                    sram_ub_n,
	output logic                    sram_lb_n
);

	import sram_dma_pkg::*;

	eng_sel_e                owner;
	dma_req_e                req_code;
	logic                    act_s1, act_s2, act_s3;
	logic                    req_edge;
	logic [`SRAM_DATA_W-1:0] pin_dq;
	logic                    pin_oe;

	assign req_code = dma_req_e'(vend_req_request);
	assign req_edge = act_s2 & ~act_s3;

	always_ff @(posedge clk) begin
		if (!reset_2) begin
			{act_s3, act_s2, act_s1} <= 3'b000;
			owner    <= SEL_NONE;
			rd_start <= 1'b0;
			wr_start <= 1'b0;
		end else begin
			{act_s3, act_s2, act_s1} <= {act_s2, act_s1, vend_req_act};
			rd_start <= 1'b0;
			wr_start <= 1'b0;
			if ((owner == SEL_READ && rd_done) || (owner == SEL_WRITE && wr_done))
				owner <= SEL_NONE;
			// new requests only when both engines are idle
			if (req_edge && owner == SEL_NONE) begin
				case (req_code)
				REQ_READ: begin
					owner    <= SEL_READ;
					rd_start <= 1'b1;
				end
				REQ_WRITE: begin
					owner    <= SEL_WRITE;
					wr_start <= 1'b1;
				end
				default: owner <= SEL_NONE;
				endcase
			end
		end
	end

	// block number to first word address
	always_ff @(posedge clk) begin
		if (req_edge && owner == SEL_NONE)
			base_addr <= `SRAM_ADDR_W'(vend_req_val) << `BLOCK_SHIFT;
	end

	always_comb begin
		case (owner)
		SEL_READ: begin
			sram_addr = rd_bus.addr;
			sram_oe_n = rd_bus.oe_n;
			sram_we_n = rd_bus.we_n;
			pin_dq    = rd_bus.dq_out;
			pin_oe    = rd_bus.dq_oe;
		end
		SEL_WRITE: begin
			sram_addr = wr_bus.addr;
			sram_oe_n = wr_bus.oe_n;
			sram_we_n = wr_bus.we_n;
			pin_dq    = wr_bus.dq_out;
			pin_oe    = wr_bus.dq_oe;
		end
		default: begin
			sram_addr = '0;
			sram_oe_n = 1'b1;
			sram_we_n = 1'b1;
			pin_dq    = '0;
			pin_oe    = 1'b0;
		end
		endcase
	end

	assign sram_dq = pin_oe ? pin_dq : 'z;

	assign rd_bus.dq_in = sram_dq;
	assign wr_bus.dq_in = sram_dq;

	// chip always selected, both byte lanes on
	assign sram_ce_n = 1'b0;
	assign sram_ub_n = 1'b0;
	assign sram_lb_n = 1'b0;

endmodule

//--- sram_read_engine.sv
// SRAM to input endpoint buffer mover
// reads one block word by word, writes two bytes per word high first,
// then commits the buffer
`include "sram_dma_cfg.svh"

module sram_read_engine (
	input  logic                   clk,
	input  logic                   reset_2,
	input  logic                   start,
	input  logic [`SRAM_ADDR_W-1:0] base_addr,
	output logic                   done,
	output logic [`BUF_ADDR_W-1:0] buf_in_addr,
	output logic [7:0]             buf_in_data,
	output logic                   buf_in_wren,
	input  logic                   buf_in_ready,
	output logic                   buf_in_commit,
	output logic [9:0]             buf_in_commit_len,
	sram_port_if.engine            sram
);

	localparam int CNT_W = $clog2(`BLOCK_WORDS);

	typedef enum logic [2:0] {
		R_IDLE, R_WAIT, R_SAMPLE, R_WR_HI, R_HI_END, R_LO, R_WR_LO, R_LO_END
	} rd_state_e;

	rd_state_e       state;
	logic [CNT_W-1:0] word_cnt;
	logic            ready_s1, ready_s2;
	logic [7:0]      lo_byte;

	// read side never drives the data bus
	assign sram.dq_out = '0;
	assign sram.dq_oe  = 1'b0;
	assign sram.we_n   = 1'b1;

	assign buf_in_commit_len = 10'(2 * `BLOCK_WORDS);

	always_ff @(posedge clk) begin
		if (!reset_2) begin
			state         <= R_IDLE;
			word_cnt      <= '0;
			buf_in_addr   <= '0;
			buf_in_wren   <= 1'b0;
			buf_in_commit <= 1'b0;
			done          <= 1'b0;
			sram.oe_n     <= 1'b1;
			ready_s1      <= 1'b0;
			ready_s2      <= 1'b0;
		end else begin
			ready_s1      <= buf_in_ready;
			ready_s2      <= ready_s1;
			buf_in_commit <= 1'b0;
			done          <= 1'b0;
			case (state)
			R_IDLE: begin
				if (start) begin
					word_cnt    <= '0;
					buf_in_addr <= '0;
					sram.oe_n   <= 1'b0;
					state       <= R_WAIT;
				end
			end
			// stall here until the buffer has room
			R_WAIT:   if (ready_s2) state <= R_SAMPLE;
			R_SAMPLE: state <= R_WR_HI;
			R_WR_HI: begin
				buf_in_wren <= 1'b1;
				state       <= R_HI_END;
			end
			R_HI_END: begin
				buf_in_wren <= 1'b0;
				state       <= R_LO;
			end
			R_LO: begin
				buf_in_addr <= buf_in_addr + 1'b1;
				state       <= R_WR_LO;
			end
			R_WR_LO: begin
				buf_in_wren <= 1'b1;
				state       <= R_LO_END;
			end
			R_LO_END: begin
				buf_in_wren <= 1'b0;
				buf_in_addr <= buf_in_addr + 1'b1;
				word_cnt    <= word_cnt + 1'b1;
				state       <= R_WAIT;
				if (word_cnt == CNT_W'(`BLOCK_WORDS - 1)) begin
					sram.oe_n     <= 1'b1;
					buf_in_commit <= 1'b1;
					done          <= 1'b1;
					state         <= R_IDLE;
				end
			end
			default: state <= R_IDLE;
			endcase
		end
	end

	// word address and byte data path
	always_ff @(posedge clk) begin
		if (state == R_IDLE && start)
			sram.addr <= base_addr;
		else if (state == R_LO_END)
			sram.addr <= sram.addr + 1'b1;
		if (state == R_SAMPLE) begin
			buf_in_data <= sram.dq_in[`SRAM_DATA_W-1 -: 8];
			lo_byte     <= sram.dq_in[7:0];
		end else if (state == R_LO) begin
			buf_in_data <= lo_byte;
		end
	end

endmodule

//--- sram_write_engine.sv
// output endpoint buffer to SRAM mover
// packs byte pairs into words, strobes each into one block,
// then re-arms the buffer and waits out the ack handshake
`include "sram_dma_cfg.svh"

module sram_write_engine (
	input  logic                   clk,
	input  logic                   reset_2,
	input  logic                   start,
	input  logic [`SRAM_ADDR_W-1:0] base_addr,
	output logic                   done,
	output logic [`BUF_ADDR_W-1:0] buf_out_addr,
	input  logic [7:0]             buf_out_q,
	input  logic                   buf_out_hasdata,
	output logic                   buf_out_arm,
	input  logic                   buf_out_arm_ack,
	sram_port_if.engine            sram
);

	localparam int CNT_W = $clog2(`BLOCK_WORDS);

	typedef enum logic [3:0] {
		W_IDLE, W_WAIT_DATA, W_LOAD_HI, W_DELAY, W_LOAD_LO, W_SETUP,
		W_STROBE, W_RELEASE, W_ACK_RISE, W_ACK_FALL, W_TAIL
	} wr_state_e;

	wr_state_e        state;
	logic [CNT_W-1:0] word_cnt;
	logic [2:0]       tail_cnt;
	logic             hasdata_s1, hasdata_s2;
	logic             ack_s1, ack_s2;

	assign sram.oe_n = 1'b1;

	always_ff @(posedge clk) begin
		if (!reset_2) begin
			state        <= W_IDLE;
			word_cnt     <= '0;
			tail_cnt     <= '0;
			buf_out_addr <= '0;
			buf_out_arm  <= 1'b0;
			done         <= 1'b0;
			sram.dq_oe   <= 1'b0;
			sram.we_n    <= 1'b1;
			{hasdata_s2, hasdata_s1} <= 2'b00;
			{ack_s2, ack_s1}         <= 2'b00;
		end else begin
			{hasdata_s2, hasdata_s1} <= {hasdata_s1, buf_out_hasdata};
			{ack_s2, ack_s1}         <= {ack_s1, buf_out_arm_ack};
			buf_out_arm <= 1'b0;
			done        <= 1'b0;
			case (state)
			W_IDLE: begin
				if (start) begin
					word_cnt     <= '0;
					buf_out_addr <= '0;
					state        <= W_WAIT_DATA;
				end
			end
			W_WAIT_DATA: if (hasdata_s2) state <= W_LOAD_HI;
			W_LOAD_HI: begin
				// previous word is written, let go of the bus
				sram.dq_oe   <= 1'b0;
				buf_out_addr <= buf_out_addr + 1'b1;
				state        <= W_DELAY;
			end
			W_DELAY: state <= W_LOAD_LO;
			W_LOAD_LO: begin
				buf_out_addr <= buf_out_addr + 1'b1;
				state        <= W_SETUP;
			end
			W_SETUP: begin
				sram.dq_oe <= 1'b1;
				state      <= W_STROBE;
			end
			W_STROBE: begin
				sram.we_n <= 1'b0;
				state     <= W_RELEASE;
			end
			W_RELEASE: begin
				sram.we_n <= 1'b1;
				word_cnt  <= word_cnt + 1'b1;
				state     <= W_LOAD_HI;
				if (word_cnt == CNT_W'(`BLOCK_WORDS - 1)) begin
					buf_out_arm <= 1'b1;
					state       <= W_ACK_RISE;
				end
			end
			W_ACK_RISE: begin
				sram.dq_oe <= 1'b0;
				if (ack_s2) state <= W_ACK_FALL;
			end
			W_ACK_FALL: begin
				tail_cnt <= '0;
				if (!ack_s2) state <= W_TAIL;
			end
			// settle time after the ack drops
			W_TAIL: begin
				tail_cnt <= tail_cnt + 1'b1;
				if (tail_cnt == 3'd7) begin
					done  <= 1'b1;
					state <= W_IDLE;
				end
			end
			default: state <= W_IDLE;
			endcase
		end
	end

	// word address and data assembly
	always_ff @(posedge clk) begin
		if (state == W_IDLE && start)
			sram.addr <= base_addr;
		else if (state == W_RELEASE)
			sram.addr <= sram.addr + 1'b1;
		if (state == W_LOAD_HI)
			sram.dq_out[`SRAM_DATA_W-1 -: 8] <= buf_out_q;
		if (state == W_LOAD_LO)
			sram.dq_out[7:0] <= buf_out_q;
	end

endmodule

//--- sram_dma.sv
// SRAM block mover top level
// bus controller plus read and write engines sharing one SRAM
`include "sram_dma_cfg.svh"

module sram_dma (
	input  logic                    clk,
	input  logic                    reset_2,
	output logic [`SRAM_ADDR_W-1:0] sram_addr,
	inout  wire  [`SRAM_DATA_W-1:0] sram_dq,
	output logic                    sram_ce_n,
	output logic                    sram_oe_n,
	output logic                    sram_we_n,
	output logic                    sram_ub_n,
	output logic                    sram_lb_n,
	output logic [`BUF_ADDR_W-1:0]  buf_in_addr,
	output logic [7:0]              buf_in_data,
	output logic                    buf_in_wren,
	input  logic                    buf_in_ready,
	output logic                    buf_in_commit,
	output logic [9:0]              buf_in_commit_len,
	output logic [`BUF_ADDR_W-1:0]  buf_out_addr,
	input  logic [7:0]              buf_out_q,
	input  logic                    buf_out_hasdata,
	output logic                    buf_out_arm,
	input  logic                    buf_out_arm_ack,
	input  logic                    vend_req_act,
	input  logic [7:0]              vend_req_request,
	input  logic [15:0]             vend_req_val
);

	logic                    rd_start, wr_start;
	logic                    rd_done, wr_done;
	logic [`SRAM_ADDR_W-1:0] base_addr;

	sram_port_if rd_bus ();
	sram_port_if wr_bus ();

	sram_bus_ctrl u_bus_ctrl (
		.clk              (clk),
		.reset_2          (reset_2),
		.vend_req_act     (vend_req_act),
		.vend_req_request (vend_req_request),
		.vend_req_val     (vend_req_val),
		.rd_done          (rd_done),
		.wr_done          (wr_done),
		.rd_start         (rd_start),
		.wr_start         (wr_start),
		.base_addr        (base_addr),
		.rd_bus           (rd_bus.bus),
		.wr_bus           (wr_bus.bus),
		.sram_addr        (sram_addr),
		.sram_dq          (sram_dq),
		.sram_ce_n        (sram_ce_n),
		.sram_oe_n        (sram_oe_n),
		.sram_we_n        (sram_we_n),
		.sram_ub_n        (sram_ub_n),
		.sram_lb_n        (sram_lb_n)
	);

	sram_read_engine u_read (
		.clk               (clk),
		.reset_2           (reset_2),
		.start             (rd_start),
		.base_addr         (base_addr),
		.done              (rd_done),
		.buf_in_addr       (buf_in_addr),
		.buf_in_data       (buf_in_data),
		.buf_in_wren       (buf_in_wren),
		.buf_in_ready      (buf_in_ready),
		.buf_in_commit     (buf_in_commit),
		.buf_in_commit_len (buf_in_commit_len),
		.sram              (rd_bus.engine)
	);

	sram_write_engine u_write (
		.clk             (clk),
		.reset_2         (reset_2),
		.start           (wr_start),
		.base_addr       (base_addr),
		.done            (wr_done),
		.buf_out_addr    (buf_out_addr),
		.buf_out_q       (buf_out_q),
		.buf_out_hasdata (buf_out_hasdata),
		.buf_out_arm     (buf_out_arm),
		.buf_out_arm_ack (buf_out_arm_ack),
		.sram            (wr_bus.engine)
	);

endmodule

//--- sram_dma_asserts.sv
// SRAM block mover protocol assertions
// strobe ordering on the SRAM pins and single-cycle buffer pulses
module sram_dma_asserts (
	input logic clk,
	input logic reset_2,
	input logic sram_oe_n,
	input logic sram_we_n,
	input logic dq_oe,
	input logic buf_in_commit,
	input logic buf_out_arm
);

	// data must be on the pins a cycle before the write strobe
	we_after_oe: assert property (@(posedge clk) disable iff (!reset_2)
		!sram_we_n |-> ($past(dq_oe) && dq_oe))
		else $error("write strobe without data set up a cycle earlier");

	no_bus_fight: assert property (@(posedge clk) disable iff (!reset_2)
		!(!sram_oe_n && !sram_we_n))
		else $error("oe_n and we_n low together");

	commit_pulse: assert property (@(posedge clk) disable iff (!reset_2)
		buf_in_commit |=> !buf_in_commit)
		else $error("commit longer than one cycle");

	arm_pulse: assert property (@(posedge clk) disable iff (!reset_2)
		buf_out_arm |=> !buf_out_arm)
		else $error("arm longer than one cycle");

endmodule

//--- tb_sram_dma.sv
// testbench for the SRAM block mover
// SRAM and endpoint buffer models, requests from the input data file
bind sram_dma sram_dma_asserts u_asserts (
	.clk           (clk),
	.reset_2       (reset_2),
	.sram_oe_n     (sram_oe_n),
	.sram_we_n     (sram_we_n),
	.dq_oe         (u_bus_ctrl.pin_oe),
	.buf_in_commit (buf_in_commit),
	.buf_out_arm   (buf_out_arm)
);

module tb_sram_dma;

	localparam int CYCLES_PER_LINE = 256 * 12;
	localparam int MAX_LINES = 16;

	logic        clk = 1'b0;
	logic        reset_2;
	wire  [19:0] sram_addr;
	wire  [15:0] sram_dq;
	wire         sram_ce_n, sram_oe_n, sram_we_n, sram_ub_n, sram_lb_n;
	wire  [8:0]  buf_in_addr, buf_out_addr;
	wire  [7:0]  buf_in_data, buf_out_q;
	wire         buf_in_wren, buf_in_commit, buf_out_arm;
	wire  [9:0]  buf_in_commit_len;
	logic        buf_in_ready, buf_out_hasdata, buf_out_arm_ack;
	logic        vend_req_act;
	logic [7:0]  vend_req_request;
	logic [15:0] vend_req_val;

	logic [15:0] mem [0:(1 << 20) - 1];
	logic [7:0]  ibuf [0:511];
	logic [7:0]  obuf [0:511];
	logic [15:0] vec [0:3*MAX_LINES-1];
	logic [15:0] snap [0:255];
	logic [19:0] wr_addr;
	logic [15:0] wr_data;
	int          n_lines;
	int          commit_cnt;
	int          arm_cnt;
	logic        loaded = 1'b0;

	sram_dma uut (.*);

	always #50 clk = ~clk;

	// asynchronous SRAM, address and data captured while we_n is low
	assign sram_dq = (!sram_ce_n && !sram_oe_n) ? mem[sram_addr] : 16'hzzzz;
	always @(negedge sram_we_n) begin
		wr_addr = sram_addr;
		wr_data = sram_dq;
	end
	always @(posedge sram_we_n) begin
		if (reset_2 && !sram_ce_n)
			mem[wr_addr] = wr_data;
	end

	assign buf_out_q = obuf[buf_out_addr];

	always @(posedge clk) begin
		if (buf_in_wren)
			ibuf[buf_in_addr] <= buf_in_data;
		if (reset_2 && buf_in_commit) begin
			commit_cnt <= commit_cnt + 1;
			check("buf_in_commit_len", 32'(buf_in_commit_len), 32'd512);
		end
		if (reset_2 && buf_out_arm)
			arm_cnt <= arm_cnt + 1;
	end

	// ack responder, rise a few cycles after arm then fall
	initial begin
		buf_out_arm_ack = 1'b0;
		forever begin
			@(posedge clk);
			if (buf_out_arm) begin
				repeat (3) @(negedge clk);
				buf_out_arm_ack = 1'b1;
				repeat (5) @(negedge clk);
				buf_out_arm_ack = 1'b0;
			end
		end
	end

	initial begin
		wait (loaded);
		repeat (n_lines * CYCLES_PER_LINE + 5000) @(posedge clk);
		$display("timeout: a request never finished within the cycle budget");
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
			$display("test failed");
			$fatal(1, "check mismatch");
		end
	endtask

	task automatic issue(input logic [7:0] code, input logic [15:0] blk);
		@(negedge clk);
		vend_req_request = code;
		vend_req_val     = blk;
		vend_req_act     = 1'b1;
		repeat (4) @(negedge clk);
		vend_req_act = 1'b0;
	endtask

	task automatic take_snapshot(input logic [15:0] blk);
		for (int k = 0; k < 256; k++)
			snap[k] = mem[20'((int'(blk) << 8) + k)];
	endtask

	task automatic compare_snapshot(input logic [15:0] blk);
		for (int k = 0; k < 256; k++)
			check("sram word kept", 32'(mem[20'((int'(blk) << 8) + k)]), 32'(snap[k]));
	endtask

	task automatic write_block(input logic [15:0] blk, input logic [15:0] flag);
		int          a0;
		logic [15:0] w;
		a0 = arm_cnt;
		take_snapshot(blk + 16'd1);
		for (int i = 0; i < 512; i++)
			obuf[i] = 8'($urandom);
		issue(8'h02, blk);
		// second edge while the write engine is busy
		if (flag == 16'd2) begin
			repeat (10) @(negedge clk);
			vend_req_val = blk + 16'd1;
			vend_req_act = 1'b1;
			repeat (4) @(negedge clk);
			vend_req_act = 1'b0;
		end
		do @(negedge clk); while (!uut.wr_done);
		check("buf_out_arm pulses", 32'(arm_cnt - a0), 32'd1);
		for (int k = 0; k < 256; k++) begin
			w = mem[20'((int'(blk) << 8) + k)];
			check("sram word", 32'(w), 32'({obuf[2*k], obuf[2*k+1]}));
		end
		if (flag == 16'd2)
			compare_snapshot(blk + 16'd1);
		repeat (4) @(negedge clk);
	endtask

	task automatic read_block(input logic [15:0] blk, input logic [15:0] flag);
		int          c0;
		logic [15:0] w;
		c0 = commit_cnt;
		for (int i = 0; i < 512; i++)
			ibuf[i] = 8'(~i) ^ 8'(i >> 8);
		issue(8'h01, blk);
		// ready held low longer than a whole block takes
		if (flag == 16'd2) begin
			repeat (300) @(negedge clk);
			buf_in_ready = 1'b0;
			// a word already under way may still finish
			repeat (10) @(negedge clk);
			for (int t = 0; t < 2000; t++) begin
				@(negedge clk);
				check("buf_in_wren while stalled", 32'(buf_in_wren), 32'd0);
			end
			check("buf_in_commit while stalled", 32'(commit_cnt - c0), 32'd0);
			buf_in_ready = 1'b1;
		end
		do @(negedge clk); while (commit_cnt == c0);
		repeat (4) @(negedge clk);
		check("buf_in_commit pulses", 32'(commit_cnt - c0), 32'd1);
		for (int k = 0; k < 256; k++) begin
			w = mem[20'((int'(blk) << 8) + k)];
			check("buf_in byte hi", 32'(ibuf[2*k]), 32'(w[15:8]));
			check("buf_in byte lo", 32'(ibuf[2*k+1]), 32'(w[7:0]));
		end
	endtask

	task automatic expect_ignored(input logic [7:0] code, input logic [15:0] blk);
		int c0;
		int a0;
		c0 = commit_cnt;
		a0 = arm_cnt;
		take_snapshot(blk);
		issue(code, blk);
		// long enough for any started engine to finish a block
		repeat (CYCLES_PER_LINE) @(negedge clk);
		check("buf_in_commit pulses", 32'(commit_cnt - c0), 32'd0);
		check("buf_out_arm pulses", 32'(arm_cnt - a0), 32'd0);
		compare_snapshot(blk);
	endtask

	initial begin
		logic [15:0] code;
		logic [15:0] blk;
		logic [15:0] flag;
		reset_2          = 1'b0;
		buf_in_ready     = 1'b1;
		buf_out_hasdata  = 1'b1;
		vend_req_act     = 1'b0;
		vend_req_request = 8'h00;
		vend_req_val     = 16'h0000;
		commit_cnt       = 0;
		arm_cnt          = 0;
		void'($urandom(32'hfae8175d));
		// pattern built from every address bit
		for (int a = 0; a < (1 << 20); a++)
			mem[a] = 16'(a * 40503) ^ 16'(a >> 16);
		for (int i = 0; i < 3 * MAX_LINES; i++)
			vec[i] = 16'hffff;
		$readmemh("sram_dma_input.txt", vec);
		n_lines = 0;
		while (n_lines < MAX_LINES && vec[3*n_lines] != 16'hffff)
			n_lines++;
		loaded = 1'b1;
		repeat (4) @(negedge clk);
		reset_2 = 1'b1;
		@(negedge clk);
		check("sram_ce_n", 32'(sram_ce_n), 32'd0);
		check("sram_ub_n", 32'(sram_ub_n), 32'd0);
		check("sram_lb_n", 32'(sram_lb_n), 32'd0);
		check("sram_oe_n", 32'(sram_oe_n), 32'd1);
		check("sram_we_n", 32'(sram_we_n), 32'd1);
		check("sram_dq drive", 32'(uut.u_bus_ctrl.pin_oe), 32'd0);
		check("buf_in_wren", 32'(buf_in_wren), 32'd0);
		check("buf_in_commit", 32'(buf_in_commit), 32'd0);
		check("buf_out_arm", 32'(buf_out_arm), 32'd0);
		for (int n = 0; n < n_lines; n++) begin
			code = vec[3*n];
			blk  = vec[3*n+1];
			flag = vec[3*n+2];
			if (code == 16'h0002 && flag != 16'd0)
				write_block(blk, flag);
			else if (code == 16'h0001 && flag != 16'd0)
				read_block(blk, flag);
			else
				expect_ignored(code[7:0], blk);
		end
		$display("test passed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+.
sram_dma_pkg.sv
sram_port_if.sv
sram_bus_ctrl.sv
sram_read_engine.sv
sram_write_engine.sv
sram_dma.sv
sram_dma_asserts.sv
tb_sram_dma.sv

//--- Makefile
# Verilator build and run for the SRAM block mover testbench

VERILATOR ?= verilator
TOP       ?= tb_sram_dma
OBJ_DIR   ?= obj_dir
FLIST     ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := sram_dma_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sram_dma_input.txt
// code block flag (hex); flag 0 no effect, 1 normal, 2 disturbed
// disturbed write gets a second request edge, disturbed read a ready drop
02 0003 1
01 0003 1
07 0003 0
02 0010 2
01 0010 2
01 0003 1
